// ==== Bender.yml ====
package:
  name: msg_testnet

sources:
  - net_msg_pkg.sv
  - net_ctrl_pkg.sv
  - net_ctrl_regs.sv
  - msg_source.sv
  - msg_merge.sv
  - msg_checker.sv
  - msg_testnet_top.sv
  - target: test
    files:
      - tb_msg_testnet.sv

// ==== build.f ====
net_msg_pkg.sv
net_ctrl_pkg.sv
net_ctrl_regs.sv
msg_source.sv
msg_merge.sv
msg_checker.sv
msg_testnet_top.sv
tb_msg_testnet.sv

// ==== msg_checker.sv ====
`timescale 1ns/1ns

module msg_checker
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
(
	input logic snk0_clk,
	input logic reset,
	input logic req,
	input logic [ASZ-1:0] src,
	input logic [ASZ-1:0] dst,
	input logic [DSZ-1:0] dat,
	input logic [RSZ-1:0] red,
	input ctrl_op_t cmd_op,
	input logic cmd_valid,
	output logic ack,
	output logic ck_valid,
	output logic [ASZ-1:0] ck_src,
	output logic [DSZ-1:0] ck_dat,
	output logic [STAT_W-1:0] status_bits,
	output logic [DSZ-1:0] fst_err_inp,
	output logic [DSZ-1:0] fst_err_dat,
	output logic [RX_CNT_W-1:0] rx_count
);

	logic [DSZ-1:0] last_dat [NUM_SRC];
	logic [NUM_SRC-1:0] err_src;
	logic rng_err;
	logic fst_cap;
	logic cks_done;
	logic take;
	logic src_ok;
	logic seq_bad;
	logic [SRC_IW-1:0] sidx;
	logic [RSZ-1:0] exp_red;

	assign exp_red = calc_redun(src, dst, dat);
	assign sidx = src[SRC_IW-1:0];
	assign src_ok = (src < NUM_SRC);
	assign take = req && !ack && !cks_done;
	// 15 is the wrap point, anything may follow it
	assign seq_bad = (last_dat[sidx] <= 14) && (dat != last_dat[sidx] + 1'b1);
	assign status_bits = {rng_err, err_src};

	always_ff @(posedge snk0_clk) begin
		if (reset) begin
			ack <= 1'b0;
			cks_done <= 1'b0;
			ck_valid <= 1'b0;
			err_src <= '0;
			rng_err <= 1'b0;
			fst_cap <= 1'b0;
			fst_err_inp <= '0;
			fst_err_dat <= '0;
			rx_count <= '0;
			for (int i = 0; i < NUM_SRC; i++) begin
				last_dat[i] <= DSZ'(15);
			end
		end else begin
			ck_valid <= 1'b0;
			if (take) begin
				cks_done <= 1'b1;
				if (dat > 15) begin
					rng_err <= 1'b1;
				end
				if (src_ok && !err_src[sidx]) begin
					if (red != exp_red) begin
						err_src[sidx] <= 1'b1;
					end else if (seq_bad) begin
						err_src[sidx] <= 1'b1;
						if (!fst_cap) begin
							fst_cap <= 1'b1;
							fst_err_inp <= dat;
							fst_err_dat <= last_dat[sidx];
						end
					end else begin
						last_dat[sidx] <= dat;
					end
				end
			end
			if (cks_done && req && !ack) begin
				cks_done <= 1'b0;
				ack <= 1'b1;
				ck_valid <= 1'b1;
				rx_count <= rx_count + 1'b1;
			end
			if (!req && ack) begin
				ack <= 1'b0;
			end
			if (cmd_valid && (cmd_op == op_clear_err)) begin
				err_src <= '0;
				rng_err <= 1'b0;
				fst_cap <= 1'b0;
				for (int i = 0; i < NUM_SRC; i++) begin
					last_dat[i] <= DSZ'(15);
				end
			end
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (take) begin
			ck_src <= src;
			ck_dat <= dat;
		end
	end

endmodule

// ==== msg_merge.sv ====
`timescale 1ns/1ns

module msg_merge
	import net_msg_pkg::*;
(
	input logic snk0_clk,
	input logic reset,
	input logic [NUM_SRC-1:0] in_req,
	input logic [ASZ-1:0] in_src [NUM_SRC],
	input logic [ASZ-1:0] in_dst [NUM_SRC],
	input logic [DSZ-1:0] in_dat [NUM_SRC],
	input logic [RSZ-1:0] in_red [NUM_SRC],
	output logic [NUM_SRC-1:0] in_ack,
	output logic out_req,
	output logic [ASZ-1:0] out_src,
	output logic [ASZ-1:0] out_dst,
	output logic [DSZ-1:0] out_dat,
	output logic [RSZ-1:0] out_red,
	input logic out_ack
);

	logic [NUM_SRC-1:0] grant;
	logic [SRC_IW-1:0] last_idx;
	logic [SRC_IW-1:0] pick_idx;
	logic pick_vld;
	logic seen_ack;

	// Search starts just after the last source served
	always_comb begin
		int cand;
		pick_vld = 1'b0;
		pick_idx = '0;
		for (int k = 1; k <= NUM_SRC; k++) begin
			cand = (int'(last_idx) + k) % NUM_SRC;
			if (!pick_vld && in_req[cand]) begin
				pick_vld = 1'b1;
				pick_idx = SRC_IW'(cand);
			end
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (reset) begin
			grant <= '0;
			seen_ack <= 1'b0;
			last_idx <= SRC_IW'(NUM_SRC - 1);
		end else if (grant == '0) begin
			seen_ack <= 1'b0;
			if (pick_vld) begin
				grant[pick_idx] <= 1'b1;
				last_idx <= pick_idx;
			end
		end else if (out_ack) begin
			seen_ack <= 1'b1;
		end else if (seen_ack && !out_req) begin
			// Handshake complete
			grant <= '0;
		end
	end

	always_comb begin
		out_req = 1'b0;
		out_src = '0;
		out_dst = '0;
		out_dat = '0;
		out_red = '0;
		for (int i = 0; i < NUM_SRC; i++) begin
			if (grant[i]) begin
				out_req = in_req[i];
				out_src = in_src[i];
				out_dst = in_dst[i];
				out_dat = in_dat[i];
				out_red = in_red[i];
			end
		end
	end

	assign in_ack = grant & {NUM_SRC{out_ack}};

	a_grant_onehot: assert property (
		@(posedge snk0_clk) disable iff (reset)
		$onehot0(grant)
	);

endmodule

// ==== msg_source.sv ====
`timescale 1ns/1ns

module msg_source
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
#(
	parameter int SRC_ID = 0
) (
	input logic snk0_clk,
	input logic reset,
	input logic en,
	input ctrl_op_t cmd_op,
	input logic [SRC_IW-1:0] cmd_src,
	input logic cmd_valid,
	input logic ack,
	output logic req,
	output logic [ASZ-1:0] src,
	output logic [ASZ-1:0] dst,
	output logic [DSZ-1:0] dat,
	output logic [RSZ-1:0] red
);

	src_state_t state;
	logic [3:0] cnt;
	logic [3:0] nib;
	logic pend_red;
	logic pend_skip;
	logic load;
	logic cmd_hit;

	assign src = ASZ'(SRC_ID);
	assign load = (state == st_idle) && en;
	assign cmd_hit = cmd_valid && (cmd_src == SRC_IW'(SRC_ID));
	// A pending skip drops one count
	assign nib = pend_skip ? cnt + 4'd1 : cnt;

	always_ff @(posedge snk0_clk) begin
		if (reset) begin
			state <= st_idle;
			req <= 1'b0;
			cnt <= '0;
			dst <= ASZ'(MIN_ADDR);
			pend_red <= 1'b0;
			pend_skip <= 1'b0;
		end else begin
			case (state)
				st_idle: if (en) begin
					cnt <= nib + 4'd1;
					state <= st_load;
				end
				st_load: if (!ack) begin
					req <= 1'b1;
					state <= st_req;
				end
				st_req: if (ack) begin
					req <= 1'b0;
					state <= st_wait_low;
				end
				st_wait_low: if (!ack) begin
					dst <= (dst >= ASZ'(MAX_ADDR)) ? ASZ'(MIN_ADDR) : dst + 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
			if (load) begin
				pend_red <= 1'b0;
				pend_skip <= 1'b0;
			end
			if (cmd_hit && (cmd_op == op_corrupt_red)) begin
				pend_red <= 1'b1;
			end
			if (cmd_hit && (cmd_op == op_skip_seq)) begin
				pend_skip <= 1'b1;
			end
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (load) begin
			dat <= DSZ'(nib);
			red <= calc_redun(src, dst, DSZ'(nib)) ^ {RSZ{pend_red}};
		end
	end

	a_fields_stable: assert property (
		@(posedge snk0_clk) disable iff (reset)
		(req && !ack) |=> $stable({dst, dat, red})
	);

endmodule

// ==== msg_testnet_top.sv ====
`timescale 1ns/1ns

module msg_testnet_top
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
(
	input logic snk0_clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [WB_AW-1:0] wb_adr,
	input logic [WB_DW-1:0] wb_dat_w,
	output logic [WB_DW-1:0] wb_dat_r,
	output logic wb_ack,
	output logic ck_valid,
	output logic [ASZ-1:0] ck_src,
	output logic [DSZ-1:0] ck_dat,
	output logic err
);

	logic [NUM_SRC-1:0] src_en;
	ctrl_op_t cmd_op;
	logic [SRC_IW-1:0] cmd_src;
	logic cmd_valid;
	logic [STAT_W-1:0] status_bits;
	logic [DSZ-1:0] fst_err_inp;
	logic [DSZ-1:0] fst_err_dat;
	logic [RX_CNT_W-1:0] rx_count;

	// Source channels
	logic [NUM_SRC-1:0] ch_req;
	logic [NUM_SRC-1:0] ch_ack;
	logic [ASZ-1:0] ch_src [NUM_SRC];
	logic [ASZ-1:0] ch_dst [NUM_SRC];
	logic [DSZ-1:0] ch_dat [NUM_SRC];
	logic [RSZ-1:0] ch_red [NUM_SRC];

	// Merged channel
	logic m_req;
	logic m_ack;
	logic [ASZ-1:0] m_src;
	logic [ASZ-1:0] m_dst;
	logic [DSZ-1:0] m_dat;
	logic [RSZ-1:0] m_red;

	net_ctrl_regs i_regs (
		.snk0_clk(snk0_clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.src_en(src_en), .cmd_op(cmd_op), .cmd_src(cmd_src), .cmd_valid(cmd_valid),
		.status_bits(status_bits), .fst_err_inp(fst_err_inp),
		.fst_err_dat(fst_err_dat), .rx_count(rx_count)
	);

	for (genvar g = 0; g < NUM_SRC; g++) begin : g_src
		msg_source #(.SRC_ID(g)) i_src (
			.snk0_clk(snk0_clk), .reset(reset), .en(src_en[g]),
			.cmd_op(cmd_op), .cmd_src(cmd_src), .cmd_valid(cmd_valid),
			.ack(ch_ack[g]), .req(ch_req[g]),
			.src(ch_src[g]), .dst(ch_dst[g]), .dat(ch_dat[g]), .red(ch_red[g])
		);
	end

	msg_merge i_merge (
		.snk0_clk(snk0_clk), .reset(reset),
		.in_req(ch_req), .in_src(ch_src), .in_dst(ch_dst),
		.in_dat(ch_dat), .in_red(ch_red), .in_ack(ch_ack),
		.out_req(m_req), .out_src(m_src), .out_dst(m_dst),
		.out_dat(m_dat), .out_red(m_red), .out_ack(m_ack)
	);

	msg_checker i_checker (
		.snk0_clk(snk0_clk), .reset(reset),
		.req(m_req), .src(m_src), .dst(m_dst), .dat(m_dat), .red(m_red),
		.cmd_op(cmd_op), .cmd_valid(cmd_valid),
		.ack(m_ack), .ck_valid(ck_valid), .ck_src(ck_src), .ck_dat(ck_dat),
		.status_bits(status_bits), .fst_err_inp(fst_err_inp),
		.fst_err_dat(fst_err_dat), .rx_count(rx_count)
	);

	assign err = |status_bits;

endmodule

// ==== net_ctrl_pkg.sv ====
package net_ctrl_pkg;

	// Wishbone control port
	localparam int WB_AW = 3;
	localparam int WB_DW = 16;

	// Register map
	localparam logic [WB_AW-1:0] REG_CTRL = 3'd0;
	localparam logic [WB_AW-1:0] REG_CMD = 3'd1;
	localparam logic [WB_AW-1:0] REG_STATUS = 3'd2;
	localparam logic [WB_AW-1:0] REG_FST_ERR = 3'd3;
	localparam logic [WB_AW-1:0] REG_RX_COUNT = 3'd4;

	// Command word layout
	localparam int CMD_OP_W = 4;
	localparam int CMD_SRC_LSB = 4;

	// Status is one bit per source plus the range error
	localparam int STAT_W = 3;
	localparam int RX_CNT_W = 16;

	typedef enum logic [CMD_OP_W-1:0] {
		op_none = 4'd0,
		op_corrupt_red = 4'd1,
		op_skip_seq = 4'd2,
		op_clear_err = 4'd3
	} ctrl_op_t;

endpackage

// ==== net_ctrl_regs.sv ====
`timescale 1ns/1ns

module net_ctrl_regs
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
(
	input logic snk0_clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [WB_AW-1:0] wb_adr,
	input logic [WB_DW-1:0] wb_dat_w,
	output logic [WB_DW-1:0] wb_dat_r,
	output logic wb_ack,
	output logic [NUM_SRC-1:0] src_en,
	output ctrl_op_t cmd_op,
	output logic [SRC_IW-1:0] cmd_src,
	output logic cmd_valid,
	input logic [STAT_W-1:0] status_bits,
	input logic [DSZ-1:0] fst_err_inp,
	input logic [DSZ-1:0] fst_err_dat,
	input logic [RX_CNT_W-1:0] rx_count
);

	logic xfer;
	logic wr_cmd;

	// One transfer per strobe, acked on the following edge
	assign xfer = wb_cyc && wb_stb && !wb_ack;
	assign wr_cmd = xfer && wb_we && (wb_adr == REG_CMD);

	always_ff @(posedge snk0_clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			src_en <= '0;
			cmd_valid <= 1'b0;
		end else begin
			wb_ack <= xfer;
			cmd_valid <= wr_cmd;
			if (xfer && wb_we && (wb_adr == REG_CTRL)) begin
				src_en <= wb_dat_w[NUM_SRC-1:0];
			end
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (wr_cmd) begin
			cmd_op <= ctrl_op_t'(wb_dat_w[CMD_OP_W-1:0]);
			cmd_src <= wb_dat_w[CMD_SRC_LSB +: SRC_IW];
		end
	end

	// Read data is captured with the ack
	always_ff @(posedge snk0_clk) begin
		if (xfer) begin
			case (wb_adr)
				REG_CTRL: wb_dat_r <= WB_DW'(src_en);
				REG_STATUS: wb_dat_r <= WB_DW'(status_bits);
				REG_FST_ERR: wb_dat_r <= {fst_err_dat, fst_err_inp};
				REG_RX_COUNT: wb_dat_r <= WB_DW'(rx_count);
				default: wb_dat_r <= '0;
			endcase
		end
	end

	a_ack_needs_strobe: assert property (
		@(posedge snk0_clk) disable iff (reset)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb)
	);

endmodule

// ==== net_msg_pkg.sv ====
package net_msg_pkg;

	// Message field widths
	localparam int ASZ = 4;
	localparam int DSZ = 8;
	localparam int RSZ = 4;

	// Number of message sources and width of a source index
	localparam int NUM_SRC = 2;
	localparam int SRC_IW = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

	// Destinations cycle over this range
	localparam int MIN_ADDR = 1;
	localparam int MAX_ADDR = 3;

	// Source FSM states
	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_req,
		st_wait_low
	} src_state_t;

	// XOR of every nibble in source, destination and data
	function automatic logic [RSZ-1:0] calc_redun(
		input logic [ASZ-1:0] src,
		input logic [ASZ-1:0] dst,
		input logic [DSZ-1:0] dat
	);
		logic [2*ASZ+DSZ-1:0] flat;
		logic [RSZ-1:0] acc;
		flat = {src, dst, dat};
		acc = '0;
		for (int i = 0; i < (2*ASZ+DSZ)/RSZ; i++) begin
			acc = acc ^ flat[i*RSZ +: RSZ];
		end
		return acc;
	endfunction

endpackage

// ==== tb_msg_testnet.sv ====
`timescale 1ns/1ns

module tb_msg_testnet
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
();

	// Step operations
	localparam logic [2:0] S_WR = 3'd0;
	localparam logic [2:0] S_RD = 3'd1;
	localparam logic [2:0] S_WAIT = 3'd2;
	localparam logic [2:0] S_ERR = 3'd3;
	localparam logic [2:0] S_SKIP = 3'd4;
	localparam logic [2:0] S_HOLD = 3'd5;

	localparam int NSTEPS = 26;
	localparam int MSG_TARGET = 80;
	localparam int WD_CYCLES = NSTEPS * 300 + MSG_TARGET * 60;

	typedef struct packed {
		logic [2:0] op;
		logic [WB_AW-1:0] adr;
		logic [15:0] dat;
		logic [15:0] exp;
		logic [15:0] mask;
	} step_t;

	// op, address, data, expected, mask
	step_t steps [NSTEPS] = '{
		'{S_RD, REG_STATUS, 16'h0000, 16'h0000, 16'hffff},
		'{S_RD, REG_RX_COUNT, 16'h0000, 16'h0000, 16'hffff},
		'{S_ERR, REG_CTRL, 16'h0000, 16'h0000, 16'h0001},
		'{S_WR, REG_CTRL, 16'h0003, 16'h0000, 16'h0000},
		'{S_WAIT, REG_RX_COUNT, 16'd40, 16'h0000, 16'h0000},
		'{S_RD, REG_STATUS, 16'h0000, 16'h0000, 16'hffff},
		'{S_ERR, REG_CTRL, 16'h0000, 16'h0000, 16'h0001},
		'{S_WR, REG_CMD, 16'h0011, 16'h0000, 16'h0000},
		'{S_WAIT, REG_RX_COUNT, 16'd48, 16'h0000, 16'h0000},
		'{S_RD, REG_STATUS, 16'h0000, 16'h0002, 16'h0007},
		'{S_ERR, REG_CTRL, 16'h0000, 16'h0001, 16'h0001},
		'{S_WR, REG_CMD, 16'h0003, 16'h0000, 16'h0000},
		'{S_RD, REG_STATUS, 16'h0000, 16'h0000, 16'hffff},
		'{S_ERR, REG_CTRL, 16'h0000, 16'h0000, 16'h0001},
		'{S_WAIT, REG_RX_COUNT, 16'd56, 16'h0000, 16'h0000},
		'{S_WR, REG_CMD, 16'h0002, 16'h0000, 16'h0000},
		'{S_WAIT, REG_RX_COUNT, 16'd64, 16'h0000, 16'h0000},
		'{S_SKIP, REG_STATUS, 16'h0000, 16'h0000, 16'h0007},
		'{S_WR, REG_CMD, 16'h0003, 16'h0000, 16'h0000},
		'{S_RD, REG_STATUS, 16'h0000, 16'h0000, 16'hffff},
		'{S_WAIT, REG_RX_COUNT, 16'(MSG_TARGET), 16'h0000, 16'h0000},
		'{S_RD, REG_STATUS, 16'h0000, 16'h0000, 16'hffff},
		'{S_ERR, REG_CTRL, 16'h0000, 16'h0000, 16'h0001},
		'{S_WR, REG_CTRL, 16'h0000, 16'h0000, 16'h0000},
		'{S_HOLD, REG_RX_COUNT, 16'd50, 16'h0000, 16'h0000},
		'{S_RD, REG_CTRL, 16'h0000, 16'h0000, 16'h0003}
	};

	logic snk0_clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_AW-1:0] wb_adr;
	logic [WB_DW-1:0] wb_dat_w;
	logic [WB_DW-1:0] wb_dat_r;
	logic wb_ack;
	logic ck_valid;
	logic [ASZ-1:0] ck_src;
	logic [DSZ-1:0] ck_dat;
	logic err;

	int errors;
	int msg_cnt;
	logic [31:0] rng;
	logic both_on;
	logic have_last;
	logic [ASZ-1:0] last_src;
	logic [DSZ-1:0] last_dat [NUM_SRC];
	logic [NUM_SRC-1:0] jump_ok;
	logic [NUM_SRC-1:0] jump_seen;
	logic [DSZ-1:0] jump_prev [NUM_SRC];
	logic [DSZ-1:0] jump_new [NUM_SRC];

	msg_testnet_top i_dut (
		.snk0_clk(snk0_clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.ck_valid(ck_valid), .ck_src(ck_src), .ck_dat(ck_dat), .err(err)
	);

	initial begin
		snk0_clk = 1'b0;
		forever #10 snk0_clk = ~snk0_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Single Wishbone classic transfer, held until ack
	task automatic bus_xfer(input logic we, input logic [WB_AW-1:0] adr,
			input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
		int n;
		@(posedge snk0_clk);
		#2;
		// Ack of the previous transfer lasts one cycle
		compare_value("wb_ack", wb_ack, 1'b0);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		n = 0;
		do begin
			@(posedge snk0_clk);
			#2;
			n++;
		end while (!wb_ack);
		compare_value("wb_ack latency", n, 1);
		rdat = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic run_step(input step_t st);
		logic [WB_DW-1:0] rd;
		logic [WB_DW-1:0] first;
		logic exp_err;
		int s;
		case (st.op)
			S_WR: begin
				if (st.adr == REG_CMD && st.dat[3:0] == op_skip_seq) begin
					jump_ok[st.dat[4]] = 1'b1;
				end
				if (st.adr == REG_CTRL) begin
					both_on = 1'b0;
				end
				bus_xfer(1'b1, st.adr, st.dat, rd);
				if (st.adr == REG_CTRL) begin
					both_on = (st.dat[1:0] == 2'b11);
				end
			end
			S_RD: begin
				bus_xfer(1'b0, st.adr, '0, rd);
				compare_value($sformatf("wb_dat_r[adr %0d]", st.adr),
					rd & st.mask, st.exp & st.mask);
			end
			S_WAIT: begin
				rd = '0;
				while (rd < st.dat) begin
					bus_xfer(1'b0, REG_RX_COUNT, '0, rd);
					if (rd < st.dat) begin
						repeat (4) @(posedge snk0_clk);
					end
				end
			end
			S_ERR: begin
				#2;
				compare_value("err", err, st.exp[0]);
			end
			S_SKIP: begin
				s = st.dat[4];
				if (!jump_seen[s]) begin
					errors++;
					$display("Skip command for source %0d never showed up in ck_dat", s);
				end else begin
					// A skip right after datum 15 is not a sequence error
					exp_err = (jump_prev[s] <= 14);
					bus_xfer(1'b0, REG_STATUS, '0, rd);
					compare_value("status_bits", rd & st.mask, 32'(exp_err) << s);
					if (exp_err) begin
						bus_xfer(1'b0, REG_FST_ERR, '0, rd);
						compare_value("fst_err", rd, {jump_prev[s], jump_new[s]});
					end
				end
			end
			S_HOLD: begin
				repeat (st.dat) @(posedge snk0_clk);
				bus_xfer(1'b0, REG_RX_COUNT, '0, first);
				compare_value("rx_count vs ck_valid count", first, msg_cnt);
				repeat (st.dat) @(posedge snk0_clk);
				bus_xfer(1'b0, REG_RX_COUNT, '0, rd);
				compare_value("rx_count after drain", rd, first);
			end
			default: begin
				errors++;
				$display("Unknown step operation %0d in the stimulus table", st.op);
			end
		endcase
	endtask

	// Reference model of each source's counting stream
	always @(negedge snk0_clk) begin : mon
		int s;
		logic [DSZ-1:0] exp_dat;
		if (!reset && ck_valid) begin
			msg_cnt++;
			s = ck_src[0];
			exp_dat = (last_dat[s] + 8'd1) & 8'h0f;
			compare_value("ck_src[3:1]", ck_src[3:1], 0);
			compare_value("ck_dat[7:4]", ck_dat[7:4], 0);
			if (ck_dat != exp_dat && jump_ok[s]) begin
				jump_ok[s] = 1'b0;
				jump_seen[s] = 1'b1;
				jump_prev[s] = last_dat[s];
				jump_new[s] = ck_dat;
				compare_value("ck_dat after skip", ck_dat, (last_dat[s] + 8'd2) & 8'h0f);
			end else begin
				compare_value("ck_dat", ck_dat, exp_dat);
			end
			if (both_on && have_last) begin
				compare_value("ck_src", ck_src, {3'b000, ~last_src[0]});
			end
			last_src = ck_src;
			have_last = 1'b1;
			last_dat[s] = ck_dat;
		end
	end

	initial begin
		errors = 0;
		msg_cnt = 0;
		rng = 32'hb2e01d5b;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		both_on = 1'b0;
		have_last = 1'b0;
		last_src = '0;
		jump_ok = '0;
		jump_seen = '0;
		for (int i = 0; i < NUM_SRC; i++) begin
			last_dat[i] = 8'd15;
			jump_prev[i] = '0;
			jump_new[i] = '0;
		end
		repeat (5) @(posedge snk0_clk);
		#2;
		reset = 1'b0;
		repeat (10) @(posedge snk0_clk);
		compare_value("ck_valid count", msg_cnt, 0);
		for (int i = 0; i < NSTEPS; i++) begin
			run_step(steps[i]);
			rng = xorshift32(rng);
			repeat (rng % 5) @(posedge snk0_clk);
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Run limit from table length and message count
	initial begin
		#(WD_CYCLES * 20);
		$display("Timeout after %0d cycles, the run did not finish", WD_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
